/* histPeak.f */
source/histPeakPkg.sv
source/sampleRouter.sv
source/pixelHistogram.sv
source/peakWindowDrain.sv
source/histPeakTop.sv
sim/histPeak_chk.sv
sim/histPeak_tb.sv

/* sim/histPeak_chk.sv */
`timescale 1ns/1ps

module histPeakChk import histPeakPkg::*; (
    input logic      clk,
    input logic      combin_res,
    input logic      sampleReq,
    input logic      sampleAck,
    input logic      resReq,
    input logic      resAck,
    input pixelIdx_t resPixel,
    input binCode_t  resPeakBin,
    input fine_t     resLower,
    input fine_t     resUpper,
    input logic      frameDone,
    input logic      drainIdle
);

    // ack only answers a request seen at the edge that raised it
    ackNeedsReq: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(sampleAck) |-> $past(sampleReq))
        else $error("sampleAck rose while sampleReq was low");

    // result fields frozen for the whole request phase
    resultHeld: assert property (@(posedge clk) disable iff (!combin_res)
        resReq && $past(resReq) |-> $stable({resPixel, resPeakBin, resLower, resUpper}))
        else $error("result data changed while resReq was high");

    // request drops only after the ack was seen
    reqWaitsForAck: assert property (@(posedge clk) disable iff (!combin_res)
        $fell(resReq) |-> $past(resAck))
        else $error("resReq fell before resAck was high");

    // no frame end can reach a busy drain
    frameEndIdle: assert property (@(posedge clk) disable iff (!combin_res)
        !(frameDone && !drainIdle))
        else $error("frameDone high while the drain was busy");

endmodule

bind histPeakTop histPeakChk i_histPeakChk (
    .clk        (clk),
    .combin_res (combin_res),
    .sampleReq  (sampleReq),
    .sampleAck  (sampleAck),
    .resReq     (resReq),
    .resAck     (resAck),
    .resPixel   (resPixel),
    .resPeakBin (resPeakBin),
    .resLower   (resLower),
    .resUpper   (resUpper),
    .frameDone  (frameDone),
    .drainIdle  (drainIdle)
);

/* sim/histPeak_tb.sv */
`timescale 1ns/1ps

module histPeak_tb import histPeakPkg::*; ();

    localparam int WAIT_LIMIT = 2000;
    localparam int MODE_RANDOM = 0;
    localparam int MODE_DIRECTED = 1;
    localparam int MODE_TIE = 2;
    localparam int LINE_ACK = 0;
    localparam int LINE_REQ = 1;
    // tie frame slot order, 1 picks the high bin
    localparam logic [5:0] TIE_ORDER = 6'b011100;
    // one forced peak per pixel
    localparam int DIRECTED_BINS [NUM_PIXELS] = '{0, 1, NUM_BINS - 1, 7};

    typedef struct packed {
        pixelIdx_t pixel;
        binCode_t  peak;
        fine_t     lower;
        fine_t     upper;
    } result_t;

    logic      clk;
    logic      combin_res;
    logic      sampleReq;
    binCode_t  sampleBin;
    logic      sampleAck;
    logic      resReq;
    pixelIdx_t resPixel;
    binCode_t  resPeakBin;
    fine_t     resLower;
    fine_t     resUpper;
    logic      resAck;

    // codes of the frame being sent, arrival order
    binCode_t frameCodes [ACQ_PER_FRAME][NUM_PIXELS][SAMPLES_PER_PIXEL];
    result_t  expected [$];
    int       resultsExpected;
    int       resultsDone;
    int       ackDelayMax;

    histPeakTop i_dut (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleReq  (sampleReq),
        .sampleBin  (sampleBin),
        .sampleAck  (sampleAck),
        .resReq     (resReq),
        .resPixel   (resPixel),
        .resPeakBin (resPeakBin),
        .resLower   (resLower),
        .resUpper   (resUpper),
        .resAck     (resAck)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abortRun();
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // four-state compare, an x or z on the DUT side never matches
    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, want);
            abortRun();
        end
    endtask

    // handshake line wait, own timeout per call
    task automatic waitLine(input int line, input logic level, input string what);
        int waited;
        waited = 0;
        while (((line == LINE_ACK) ? sampleAck : resReq) !== level) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout while waiting for %s", what);
                abortRun();
            end
        end
    endtask

    // replays one pixel's codes, strict-greater peak then window rule
    function automatic result_t expectedResult(input int pixel);
        int      counts [NUM_BINS];
        int      peakCount;
        int      code;
        int      center;
        int      half;
        int      fineMax;
        result_t r;
        half = 2 ** (BIN_WIDTH - 1);
        fineMax = 2 ** FINE_WIDTH - 1;
        peakCount = 0;
        r.pixel = pixelIdx_t'(pixel);
        r.peak = '0;
        for (int b = 0; b < NUM_BINS; b++) begin
            counts[b] = 0;
        end
        for (int a = 0; a < ACQ_PER_FRAME; a++) begin
            for (int s = 0; s < SAMPLES_PER_PIXEL; s++) begin
                code = int'(frameCodes[a][pixel][s]);
                counts[code]++;
                // on a tie the bin that got there first stays
                if (counts[code] > peakCount) begin
                    peakCount = counts[code];
                    r.peak = binCode_t'(code);
                end
            end
        end
        center = int'(r.peak) * (2 ** (FINE_WIDTH - BIN_WIDTH));
        if (center <= half) begin
            r.lower = '0;
            r.upper = fine_t'(2 * half);
        end else if (center >= fineMax - half) begin
            // top clamp, fine all-ones less coarse all-ones
            r.upper = fine_t'(fineMax - (2 ** BIN_WIDTH - 1));
            r.lower = r.upper - fine_t'(2 * half);
        end else begin
            r.lower = fine_t'(center - half);
            r.upper = fine_t'(center + half);
        end
        return r;
    endfunction

    task automatic fillFrame(input int mode);
        int slot;
        for (int a = 0; a < ACQ_PER_FRAME; a++) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                for (int s = 0; s < SAMPLES_PER_PIXEL; s++) begin
                    slot = a * SAMPLES_PER_PIXEL + s;
                    case (mode)
                        MODE_DIRECTED: begin
                            // one stray code, then the forced bin
                            frameCodes[a][p][s] = binCode_t'((slot == 0) ?
                                DIRECTED_BINS[p] + 3 : DIRECTED_BINS[p]);
                        end
                        MODE_TIE: begin
                            // odd pixels mirror the order so the low bin wins there
                            frameCodes[a][p][s] = binCode_t'((TIE_ORDER[slot] ^ p[0]) ?
                                10 + p : 2 + p);
                        end
                        default: begin
                            // narrow range half the time so bins collide
                            frameCodes[a][p][s] = binCode_t'(($urandom_range(0, 1) == 1) ?
                                $urandom_range(0, 3) : $urandom_range(0, NUM_BINS - 1));
                        end
                    endcase
                end
            end
        end
    endtask

    task automatic sendSample(input binCode_t code, input bit frameStart, input int prior);
        @(negedge clk);
        sampleBin = code;
        sampleReq = 1'b1;
        waitLine(LINE_ACK, 1'b1, "sampleAck high");
        // a new frame may only start once every earlier result is through
        if (frameStart) begin
            assert (resultsDone == prior) else begin
                $display("first sample of a frame was acknowledged with results pending");
                abortRun();
            end
        end
        sampleReq = 1'b0;
        waitLine(LINE_ACK, 1'b0, "sampleAck low");
    endtask

    task automatic sendFrame(input int mode);
        int prior;
        fillFrame(mode);
        prior = resultsExpected;
        for (int p = 0; p < NUM_PIXELS; p++) begin
            expected.push_back(expectedResult(p));
        end
        resultsExpected += NUM_PIXELS;
        for (int a = 0; a < ACQ_PER_FRAME; a++) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                for (int s = 0; s < SAMPLES_PER_PIXEL; s++) begin
                    sendSample(frameCodes[a][p][s], (a == 0) && (p == 0) && (s == 0), prior);
                end
            end
        end
    endtask

    // result side, compares each result when it acks
    task automatic resultSide();
        result_t want;
        forever begin
            waitLine(LINE_REQ, 1'b1, "resReq high");
            repeat ($urandom_range(0, ackDelayMax)) @(negedge clk);
            if (expected.size() == 0) begin
                $display("result returned with no frame outstanding");
                abortRun();
            end else begin
                want = expected.pop_front();
                checkField("resPixel", resPixel, want.pixel);
                checkField("resPeakBin", resPeakBin, want.peak);
                checkField("resLower", resLower, want.lower);
                checkField("resUpper", resUpper, want.upper);
            end
            resAck = 1'b1;
            waitLine(LINE_REQ, 1'b0, "resReq low");
            resAck = 1'b0;
            resultsDone++;
        end
    endtask

    initial begin
        int waited;
        void'($urandom(90));
        combin_res = 1'b0;
        sampleReq = 1'b0;
        sampleBin = '0;
        resAck = 1'b0;
        resultsExpected = 0;
        resultsDone = 0;
        ackDelayMax = 2;
        repeat (16) @(negedge clk);
        combin_res = 1'b1;
        fork
            resultSide();
        join_none
        sendFrame(MODE_RANDOM);
        // peaks at bins 0, 1, 15 and 7
        sendFrame(MODE_DIRECTED);
        sendFrame(MODE_TIE);
        // back to back, histograms must start empty each time
        repeat (3) sendFrame(MODE_RANDOM);
        // slow acks keep the drain busy into the next frame
        ackDelayMax = 20;
        repeat (2) sendFrame(MODE_RANDOM);
        waited = 0;
        while (resultsDone < resultsExpected) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout while waiting for the last results");
                abortRun();
            end
        end
        if (expected.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("expected results left over at the end of the run");
            abortRun();
        end
    end

endmodule

/* source/histPeakPkg.sv */
package histPeakPkg;

    // coarse bin code and histogram size
    localparam int BIN_WIDTH = 4;
    localparam int NUM_BINS = 2 ** BIN_WIDTH;

    // fine window resolution
    localparam int FINE_WIDTH = 8;

    // per-bin counter, max SAMPLES_PER_PIXEL * ACQ_PER_FRAME so no wrap
    localparam int COUNT_WIDTH = 8;

    // pixel units in this build
    localparam int NUM_PIXELS = 4;
    localparam int PIXEL_WIDTH = 2;

    // input sweep shape
    localparam int SAMPLES_PER_PIXEL = 2;
    localparam int ACQ_PER_FRAME = 3;

    // position counter widths, kept at least one bit
    localparam int SAMPLE_CNT_WIDTH = (SAMPLES_PER_PIXEL > 1) ? $clog2(SAMPLES_PER_PIXEL) : 1;
    localparam int ACQ_CNT_WIDTH = (ACQ_PER_FRAME > 1) ? $clog2(ACQ_PER_FRAME) : 1;

    typedef logic [BIN_WIDTH-1:0] binCode_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [FINE_WIDTH-1:0] fine_t;
    typedef logic [PIXEL_WIDTH-1:0] pixelIdx_t;

    // last positions of the nested counters
    localparam logic [SAMPLE_CNT_WIDTH-1:0] SAMPLE_LAST = SAMPLE_CNT_WIDTH'(SAMPLES_PER_PIXEL - 1);
    localparam logic [ACQ_CNT_WIDTH-1:0] ACQ_LAST = ACQ_CNT_WIDTH'(ACQ_PER_FRAME - 1);
    localparam pixelIdx_t PIXEL_LAST = pixelIdx_t'(NUM_PIXELS - 1);

    // window constants in fine units
    localparam fine_t HALF_WINDOW = fine_t'(2 ** (BIN_WIDTH - 1));
    localparam fine_t WINDOW_SPAN = fine_t'(2 * (2 ** (BIN_WIDTH - 1)));
    localparam fine_t FINE_MAX = fine_t'(2 ** FINE_WIDTH - 1);
    // fine all-ones minus coarse all-ones
    localparam fine_t TOP_LIMIT = fine_t'((2 ** FINE_WIDTH - 1) - (2 ** BIN_WIDTH - 1));

endpackage

/* source/histPeakTop.sv */
`timescale 1ns/1ps

module histPeakTop import histPeakPkg::*; (
    input  logic      clk,
    input  logic      combin_res,
    // sample handshake
    input  logic      sampleReq,
    input  binCode_t  sampleBin,
    output logic      sampleAck,
    // result handshake
    output logic      resReq,
    output pixelIdx_t resPixel,
    output binCode_t  resPeakBin,
    output fine_t     resLower,
    output fine_t     resUpper,
    input  logic      resAck
);

    // router to units
    logic [NUM_PIXELS-1:0] binWrite;
    binCode_t              writeBin;
    logic                  frameDone;

    // units and drain
    binCode_t peakBins [NUM_PIXELS];
    logic     clearFrame;
    logic     drainIdle;

    sampleRouter i_sampleRouter (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleReq  (sampleReq),
        .sampleBin  (sampleBin),
        .drainIdle  (drainIdle),
        .sampleAck  (sampleAck),
        .binWrite   (binWrite),
        .writeBin   (writeBin),
        .frameDone  (frameDone)
    );

    // one histogram per pixel
    for (genvar g = 0; g < NUM_PIXELS; g++) begin : g_pixel
        pixelHistogram i_pixelHistogram (
            .clk        (clk),
            .combin_res (combin_res),
            .binWrite   (binWrite[g]),
            .writeBin   (writeBin),
            .clearFrame (clearFrame),
            .peakBin    (peakBins[g])
        );
    end

    peakWindowDrain i_peakWindowDrain (
        .clk        (clk),
        .combin_res (combin_res),
        .frameDone  (frameDone),
        .peakBins   (peakBins),
        .resAck     (resAck),
        .drainIdle  (drainIdle),
        .clearFrame (clearFrame),
        .resReq     (resReq),
        .resPixel   (resPixel),
        .resPeakBin (resPeakBin),
        .resLower   (resLower),
        .resUpper   (resUpper)
    );

endmodule

/* source/peakWindowDrain.sv */
`timescale 1ns/1ps

module peakWindowDrain import histPeakPkg::*; (
    input  logic      clk,
    input  logic      combin_res,
    input  logic      frameDone,
    // live peaks from the pixel units
    input  binCode_t  peakBins [NUM_PIXELS],
    // four-phase result side
    input  logic      resAck,
    output logic      drainIdle,
    output logic      clearFrame,
    output logic      resReq,
    output pixelIdx_t resPixel,
    output binCode_t  resPeakBin,
    output fine_t     resLower,
    output fine_t     resUpper
);

    typedef enum logic [1:0] {
        DRAIN_IDLE,
        // one cycle, clears the units
        DRAIN_CLEAR,
        // resReq high, waiting for ack
        DRAIN_REQ,
        // resReq low, waiting for ack to drop
        DRAIN_RELEASE
    } drainState_t;

    drainState_t state;
    drainState_t stateNext;

    // frame snapshot so the units can restart right away
    binCode_t  capturedPeaks [NUM_PIXELS];
    pixelIdx_t pixelSel;

    fine_t center;

    always_comb begin
        stateNext = state;
        case (state)
            DRAIN_IDLE: begin
                if (frameDone) begin
                    stateNext = DRAIN_CLEAR;
                end
            end
            DRAIN_CLEAR: begin
                stateNext = DRAIN_REQ;
            end
            DRAIN_REQ: begin
                if (resAck) begin
                    stateNext = DRAIN_RELEASE;
                end
            end
            DRAIN_RELEASE: begin
                if (!resAck) begin
                    // last pixel done, input may resume
                    stateNext = (pixelSel == PIXEL_LAST) ? DRAIN_IDLE : DRAIN_REQ;
                end
            end
            default: begin
                stateNext = DRAIN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= DRAIN_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // result index walks 0 to NUM_PIXELS-1
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pixelSel <= '0;
        end else if (state == DRAIN_CLEAR) begin
            pixelSel <= '0;
        end else if (state == DRAIN_RELEASE && !resAck && pixelSel != PIXEL_LAST) begin
            pixelSel <= pixelSel + 1'b1;
        end
    end

    // snapshot at the edge that sees frameDone
    always_ff @(posedge clk) begin
        if (state == DRAIN_IDLE && frameDone) begin
            capturedPeaks <= peakBins;
        end
    end

    // status straight from the state register
    assign drainIdle = (state == DRAIN_IDLE);
    assign clearFrame = (state == DRAIN_CLEAR);
    assign resReq = (state == DRAIN_REQ);

    assign resPixel = pixelSel;
    assign resPeakBin = capturedPeaks[pixelSel];

    // peak bin in fine units
    assign center = fine_t'(resPeakBin) << (FINE_WIDTH - BIN_WIDTH);

    // window rule, low clamp checked first
    always_comb begin
        if (center <= HALF_WINDOW) begin
            resLower = '0;
            resUpper = WINDOW_SPAN;
        end else if (center >= FINE_MAX - HALF_WINDOW) begin
            // unreachable with the default widths
            resLower = TOP_LIMIT - WINDOW_SPAN;
            resUpper = TOP_LIMIT;
        end else begin
            resLower = center - HALF_WINDOW;
            resUpper = center + HALF_WINDOW;
        end
    end

endmodule

/* source/pixelHistogram.sv */
`timescale 1ns/1ps

module pixelHistogram import histPeakPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    // strobe for this unit only
    input  logic     binWrite,
    input  binCode_t writeBin,
    // frame-end clear from the drain
    input  logic     clearFrame,
    output binCode_t peakBin
);

    // bin counters, meaningful only where the valid flag is set
    count_t              binCount [NUM_BINS];
    logic [NUM_BINS-1:0] binValid;

    // running peak
    count_t peakCount;

    // count after the current write
    count_t nextCount;
    logic   newPeak;

    always_comb begin
        if (binValid[writeBin]) begin
            nextCount = binCount[writeBin] + 1'b1;
        end else begin
            // first hit of this bin in the frame
            nextCount = count_t'(1);
        end
    end

    // strictly greater, so on a tie the earlier bin keeps the peak
    assign newPeak = (nextCount > peakCount);

    // counter storage
    always_ff @(posedge clk) begin
        if (binWrite) begin
            binCount[writeBin] <= nextCount;
        end
    end

    // valid flags, cleared per frame instead of zeroing every counter
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (clearFrame) begin
            binValid <= '0;
        end else if (binWrite) begin
            binValid[writeBin] <= 1'b1;
        end
    end

    // peak tracker, updated in the same edge as the count
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakCount <= '0;
            peakBin <= '0;
        end else if (clearFrame) begin
            peakCount <= '0;
            peakBin <= '0;
        end else if (binWrite && newPeak) begin
            peakCount <= nextCount;
            peakBin <= writeBin;
        end
    end

endmodule

/* source/sampleRouter.sv */
`timescale 1ns/1ps

module sampleRouter import histPeakPkg::*; (
    input  logic                  clk,
    input  logic                  combin_res,
    // four-phase sample side
    input  logic                  sampleReq,
    input  binCode_t              sampleBin,
    // drain back-pressure
    input  logic                  drainIdle,
    output logic                  sampleAck,
    // write port towards the pixel units
    output logic [NUM_PIXELS-1:0] binWrite,
    output binCode_t              writeBin,
    output logic                  frameDone
);

    // position inside the frame sweep
    logic [SAMPLE_CNT_WIDTH-1:0] sampleCnt;
    pixelIdx_t                   pixelCnt;
    logic [ACQ_CNT_WIDTH-1:0]    acqCnt;

    logic takeSample;
    logic lastSample;
    logic lastPixel;
    logic lastAcq;
    logic atFrameStart;

    // new request, drain free, and no frame end still in flight
    // (frameDone high means the drain has not yet seen this frame close)
    assign takeSample = sampleReq && !sampleAck && drainIdle && !frameDone;

    assign lastSample = (sampleCnt == SAMPLE_LAST);
    assign lastPixel = (pixelCnt == PIXEL_LAST);
    assign lastAcq = (acqCnt == ACQ_LAST);

    // counters only come back to all zero after the final write of a frame
    assign atFrameStart = (sampleCnt == '0) && (pixelCnt == '0) && (acqCnt == '0);

    // ack side of the handshake
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleAck <= 1'b0;
        end else if (takeSample) begin
            sampleAck <= 1'b1;
        end else if (!sampleReq) begin
            // release once req is seen low
            sampleAck <= 1'b0;
        end
    end

    // one-hot write strobe, single cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binWrite <= '0;
        end else begin
            binWrite <= '0;
            if (takeSample) begin
                binWrite[pixelCnt] <= 1'b1;
            end
        end
    end

    // code travels with the strobe
    always_ff @(posedge clk) begin
        if (takeSample) begin
            writeBin <= sampleBin;
        end
    end

    // nested counters: sample, then pixel, then acquisition
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else if (takeSample) begin
            if (!lastSample) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                if (!lastPixel) begin
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    pixelCnt <= '0;
                    // acquisition wrap restarts the sweep
                    if (!lastAcq) begin
                        acqCnt <= acqCnt + 1'b1;
                    end else begin
                        acqCnt <= '0;
                    end
                end
            end
        end
    end

    // frame end one edge after the last strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frameDone <= 1'b0;
        end else begin
            frameDone <= (|binWrite) && atFrameStart;
        end
    end

endmodule
